//--- design/axi4l_bridge_pkg.sv
/* AXI4-Lite bridge shared types */
package axi4l_bridge_pkg;

  // ------------------------------------------------------------
  // Bus widths, single fixed configuration
  // ------------------------------------------------------------
  localparam int ADDR_W = 10;
  localparam int DATA_W = 32;
  // One strobe per byte lane
  localparam int STRB_W = DATA_W / 8;

  // Payload types shared by both buses
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // ------------------------------------------------------------
  // AXI response code
  // ------------------------------------------------------------
  // Internal error bit lands on both resp bits
  // So only OKAY and DECERR ever appear
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage

//--- design/wr_cmd_if.sv
/* Write command link */
`timescale 1ns/1ps

interface wr_cmd_if
  import axi4l_bridge_pkg::*;
();

  // Complete write, address and data paired
  logic  valid;
  addr_t addr;
  data_t data;
  strb_t strb;
  // Arbiter issues the command this cycle
  logic  take;

  modport capture (output valid, addr, data, strb, input take);
  modport arbiter (input valid, addr, data, strb, output take);

endinterface

//--- design/txn_track_if.sv
/* Outstanding command tracking */
`timescale 1ns/1ps

interface txn_track_if ();

  // Command outstanding on the internal bus
  logic wr_busy;
  logic rd_busy;
  // Ack has a B or R slot, busy clears next edge
  logic wr_retire;
  logic rd_retire;

  modport arbiter (output wr_busy, rd_busy, input wr_retire, rd_retire);
  modport resp (input wr_busy, rd_busy, output wr_retire, rd_retire);

endinterface

//--- design/axi_wr_capture.sv
/* AXI write address and data capture */
`timescale 1ns/1ps

module axi_wr_capture
  import axi4l_bridge_pkg::*;
(
  input  logic      aclk,
  input  logic      aresetn,
  input  addr_t     s_axi_awaddr,
  input  logic      s_axi_awvalid,
  output logic      s_axi_awready,
  input  data_t     s_axi_wdata,
  input  strb_t     s_axi_wstrb,
  input  logic      s_axi_wvalid,
  output logic      s_axi_wready,
  wr_cmd_if.capture cmd
);

  logic  aw_hsk;
  logic  w_hsk;
  logic  aw_wait;
  logic  w_wait;
  logic  aw_wait_nxt;
  logic  w_wait_nxt;
  logic  aw_ready_q;
  logic  w_ready_q;
  addr_t aw_addr_q;
  data_t w_data_q;
  strb_t w_strb_q;

  assign s_axi_awready = aw_ready_q;
  assign s_axi_wready  = w_ready_q;
  assign aw_hsk        = s_axi_awvalid & aw_ready_q;
  assign w_hsk         = s_axi_wvalid & w_ready_q;

  // ------------------------------------------------------------
  // Pairing of a live or held beat on each side
  // ------------------------------------------------------------
  assign cmd.valid = (aw_hsk | aw_wait) & (w_hsk | w_wait);
  assign cmd.addr  = aw_wait ? aw_addr_q : s_axi_awaddr;
  assign cmd.data  = w_wait ? w_data_q : s_axi_wdata;
  assign cmd.strb  = w_wait ? w_strb_q : s_axi_wstrb;

  // Take consumes both sides and otherwise a fresh beat is held
  assign aw_wait_nxt = cmd.take ? 1'b0 : (aw_hsk | aw_wait);
  assign w_wait_nxt  = cmd.take ? 1'b0 : (w_hsk | w_wait);

  // Ready tracks the registered wait flag and is low in reset
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      aw_wait    <= 1'b0;
      w_wait     <= 1'b0;
      aw_ready_q <= 1'b0;
      w_ready_q  <= 1'b0;
    end else begin
      aw_wait    <= aw_wait_nxt;
      w_wait     <= w_wait_nxt;
      aw_ready_q <= ~aw_wait_nxt;
      w_ready_q  <= ~w_wait_nxt;
    end
  end

  // Holding registers load on each handshake
  always_ff @(posedge aclk) begin
    if (aw_hsk) begin
      aw_addr_q <= s_axi_awaddr;
    end
    if (w_hsk) begin
      w_data_q <= s_axi_wdata;
      w_strb_q <= s_axi_wstrb;
    end
  end

  // Take only for a paired command
  a_take_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    cmd.take |-> cmd.valid)
    else $error("write take without a paired command");

endmodule

//--- design/axi_rd_capture.sv
/* AXI read address capture */
`timescale 1ns/1ps

module axi_rd_capture
  import axi4l_bridge_pkg::*;
(
  input  logic  aclk,
  input  logic  aresetn,
  input  addr_t s_axi_araddr,
  input  logic  s_axi_arvalid,
  output logic  s_axi_arready,
  output logic  rd_valid,
  output addr_t rd_addr,
  input  logic  rd_take
);

  logic  ar_hsk;
  logic  ar_wait;
  logic  ar_wait_nxt;
  logic  ar_ready_q;
  addr_t ar_addr_q;

  assign s_axi_arready = ar_ready_q;
  assign ar_hsk        = s_axi_arvalid & ar_ready_q;

  // Live beat passes straight through when the arbiter takes it
  assign rd_valid    = ar_hsk | ar_wait;
  assign rd_addr     = ar_wait ? ar_addr_q : s_axi_araddr;
  assign ar_wait_nxt = rd_take ? 1'b0 : rd_valid;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ar_wait    <= 1'b0;
      ar_ready_q <= 1'b0;
    end else begin
      ar_wait    <= ar_wait_nxt;
      ar_ready_q <= ~ar_wait_nxt;
    end
  end

  // Held address
  always_ff @(posedge aclk) begin
    if (ar_hsk) begin
      ar_addr_q <= s_axi_araddr;
    end
  end

  a_take_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    rd_take |-> rd_valid)
    else $error("rd_take without a read command");

endmodule

//--- design/int_bus_arbiter.sv
/* Internal bus command arbiter */
`timescale 1ns/1ps

module int_bus_arbiter
  import axi4l_bridge_pkg::*;
(
  input  logic        aclk,
  input  logic        aresetn,
  wr_cmd_if.arbiter   cmd,
  input  logic        rd_valid,
  input  addr_t       rd_addr,
  output logic        rd_take,
  txn_track_if.arbiter trk,
  output addr_t       int_addr,
  output data_t       int_wr_data,
  output strb_t       int_wr_strb,
  output logic        int_wr_en,
  output logic        int_rd_en
);

  // ------------------------------------------------------------
  // Arbitration with writes first
  // ------------------------------------------------------------
  // Any valid write blocks reads even while the write waits
  assign cmd.take = cmd.valid & ~trk.wr_busy;
  assign rd_take  = rd_valid & ~cmd.valid & ~trk.rd_busy;

  // Strobes and busy flags
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      int_wr_en   <= 1'b0;
      int_rd_en   <= 1'b0;
      trk.wr_busy <= 1'b0;
      trk.rd_busy <= 1'b0;
    end else begin
      int_wr_en <= cmd.take;
      int_rd_en <= rd_take;
      // Busy until response control retires the ack
      if (cmd.take) begin
        trk.wr_busy <= 1'b1;
      end else if (trk.wr_retire) begin
        trk.wr_busy <= 1'b0;
      end
      if (rd_take) begin
        trk.rd_busy <= 1'b1;
      end else if (trk.rd_retire) begin
        trk.rd_busy <= 1'b0;
      end
    end
  end

  // Shared address plus write payload
  always_ff @(posedge aclk) begin
    if (cmd.take) begin
      int_addr    <= cmd.addr;
      int_wr_data <= cmd.data;
      int_wr_strb <= cmd.strb;
    end else if (rd_take) begin
      int_addr <= rd_addr;
    end
  end

  // Retire only for an outstanding command
  a_wr_retire: assert property (@(posedge aclk) disable iff (!aresetn)
    trk.wr_retire |-> trk.wr_busy)
    else $error("write retire with no write outstanding");
  a_rd_retire: assert property (@(posedge aclk) disable iff (!aresetn)
    trk.rd_retire |-> trk.rd_busy)
    else $error("read retire with no read outstanding");

endmodule

//--- design/axi_resp_ctrl.sv
/* AXI B and R response control */
`timescale 1ns/1ps

module axi_resp_ctrl
  import axi4l_bridge_pkg::*;
(
  input  logic      aclk,
  input  logic      aresetn,
  txn_track_if.resp trk,
  input  logic      int_wr_ack,
  input  logic      int_wr_err,
  input  logic      int_rd_ack,
  input  logic      int_rd_err,
  input  data_t     int_rd_data,
  output resp_e     s_axi_bresp,
  output logic      s_axi_bvalid,
  input  logic      s_axi_bready,
  output data_t     s_axi_rdata,
  output resp_e     s_axi_rresp,
  output logic      s_axi_rvalid,
  input  logic      s_axi_rready
);

  logic  b_stall;
  logic  r_stall;
  logic  wr_ack_v;
  logic  rd_ack_v;
  logic  wr_pend;
  logic  rd_pend;
  logic  wr_pend_err;
  logic  rd_pend_err;
  data_t rd_pend_data;

  // Master holding off an existing response
  assign b_stall  = s_axi_bvalid & ~s_axi_bready;
  assign r_stall  = s_axi_rvalid & ~s_axi_rready;
  // Acks count only against an outstanding command
  assign wr_ack_v = int_wr_ack & trk.wr_busy;
  assign rd_ack_v = int_rd_ack & trk.rd_busy;

  // Ack owns a slot so the arbiter may clear busy
  assign trk.wr_retire = ~b_stall & (wr_pend | wr_ack_v);
  assign trk.rd_retire = ~r_stall & (rd_pend | rd_ack_v);

  // ------------------------------------------------------------
  // Pending store for an ack seen during a stall
  // ------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_pend <= 1'b0;
      rd_pend <= 1'b0;
    end else begin
      if (wr_ack_v && b_stall) begin
        wr_pend <= 1'b1;
      end else if (!b_stall) begin
        wr_pend <= 1'b0;
      end
      if (rd_ack_v && r_stall) begin
        rd_pend <= 1'b1;
      end else if (!r_stall) begin
        rd_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_ack_v) begin
      wr_pend_err <= int_wr_err;
    end
    if (rd_ack_v) begin
      rd_pend_err  <= int_rd_err;
      rd_pend_data <= int_rd_data;
    end
  end

  // ------------------------------------------------------------
  // B and R channel registers
  // ------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axi_bvalid <= 1'b0;
      s_axi_rvalid <= 1'b0;
    end else begin
      // Pending ack goes out before anything fresh
      if (!b_stall) begin
        s_axi_bvalid <= wr_pend | wr_ack_v;
      end
      if (!r_stall) begin
        s_axi_rvalid <= rd_pend | rd_ack_v;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!b_stall && wr_pend) begin
      s_axi_bresp <= wr_pend_err ? RESP_DECERR : RESP_OKAY;
    end else if (!b_stall && wr_ack_v) begin
      s_axi_bresp <= int_wr_err ? RESP_DECERR : RESP_OKAY;
    end
    if (!r_stall && rd_pend) begin
      s_axi_rresp <= rd_pend_err ? RESP_DECERR : RESP_OKAY;
      s_axi_rdata <= rd_pend_data;
    end else if (!r_stall && rd_ack_v) begin
      s_axi_rresp <= int_rd_err ? RESP_DECERR : RESP_OKAY;
      s_axi_rdata <= int_rd_data;
    end
  end

  // One ack per outstanding command and none while one is pended
  a_wr_ack: assert property (@(posedge aclk) disable iff (!aresetn)
    int_wr_ack |-> trk.wr_busy && !wr_pend)
    else $error("write ack with no write waiting for it");
  a_rd_ack: assert property (@(posedge aclk) disable iff (!aresetn)
    int_rd_ack |-> trk.rd_busy && !rd_pend)
    else $error("read ack with no read waiting for it");

endmodule

//--- design/axi4l_bridge_top.sv
/* AXI4-Lite to internal bus bridge */
`timescale 1ns/1ps

module axi4l_bridge_top
  import axi4l_bridge_pkg::*;
(
  input  logic  aclk,
  input  logic  aresetn,
  // AXI4-Lite slave
  input  addr_t s_axi_awaddr,
  input  logic  s_axi_awvalid,
  output logic  s_axi_awready,
  input  data_t s_axi_wdata,
  input  strb_t s_axi_wstrb,
  input  logic  s_axi_wvalid,
  output logic  s_axi_wready,
  output resp_e s_axi_bresp,
  output logic  s_axi_bvalid,
  input  logic  s_axi_bready,
  input  addr_t s_axi_araddr,
  input  logic  s_axi_arvalid,
  output logic  s_axi_arready,
  output data_t s_axi_rdata,
  output resp_e s_axi_rresp,
  output logic  s_axi_rvalid,
  input  logic  s_axi_rready,
  // Internal register bus
  output addr_t int_addr,
  output data_t int_wr_data,
  output strb_t int_wr_strb,
  output logic  int_wr_en,
  output logic  int_rd_en,
  input  logic  int_wr_ack,
  input  logic  int_wr_err,
  input  logic  int_rd_ack,
  input  logic  int_rd_err,
  input  data_t int_rd_data
);

  logic  rd_valid;
  addr_t rd_addr;
  logic  rd_take;

  wr_cmd_if    wr_cmd ();
  txn_track_if trk ();

  // ------------------------------------------------------------
  // Capture, arbitration, response
  // ------------------------------------------------------------
  axi_wr_capture u_axi_wr_capture (.aclk, .aresetn, .s_axi_awaddr, .s_axi_awvalid,
    .s_axi_awready, .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
    .cmd(wr_cmd.capture));

  axi_rd_capture u_axi_rd_capture (.aclk, .aresetn, .s_axi_araddr, .s_axi_arvalid,
    .s_axi_arready, .rd_valid, .rd_addr, .rd_take);

  int_bus_arbiter u_int_bus_arbiter (.aclk, .aresetn, .cmd(wr_cmd.arbiter), .rd_valid,
    .rd_addr, .rd_take, .trk(trk.arbiter), .int_addr, .int_wr_data, .int_wr_strb,
    .int_wr_en, .int_rd_en);

  axi_resp_ctrl u_axi_resp_ctrl (.aclk, .aresetn, .trk(trk.resp), .int_wr_ack,
    .int_wr_err, .int_rd_ack, .int_rd_err, .int_rd_data, .s_axi_bresp, .s_axi_bvalid,
    .s_axi_bready, .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready);

endmodule

//--- verification/tb_int_target.sv
/* Internal bus target model */
`timescale 1ns/1ps

module tb_int_target
  import axi4l_bridge_pkg::*;
(
  input  logic  aclk,
  input  logic  aresetn,
  input  addr_t int_addr,
  input  data_t int_wr_data,
  input  strb_t int_wr_strb,
  input  logic  int_wr_en,
  input  logic  int_rd_en,
  output logic  int_wr_ack,
  output logic  int_wr_err,
  output logic  int_rd_ack,
  output logic  int_rd_err,
  output data_t int_rd_data
);

  data_t  mem [256];
  integer seed;
  int     wr_cnt;
  int     rd_cnt;

  // Fill pattern built from the full word index
  initial begin
    seed = 32'h71b3;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3};
    end
  end

  // ------------------------------------------------------------
  // Strobe capture and delayed single-cycle ack
  // ------------------------------------------------------------
  always @(posedge aclk) begin
    if (!aresetn) begin
      wr_cnt      <= 0;
      rd_cnt      <= 0;
      int_wr_ack  <= 1'b0;
      int_rd_ack  <= 1'b0;
      int_wr_err  <= 1'b0;
      int_rd_err  <= 1'b0;
      int_rd_data <= '0;
    end else begin
      int_wr_ack <= (wr_cnt == 1);
      int_rd_ack <= (rd_cnt == 1);
      if (wr_cnt > 0) begin
        wr_cnt <= wr_cnt - 1;
      end
      if (rd_cnt > 0) begin
        rd_cnt <= rd_cnt - 1;
      end
      // Bit 9 set means no such register
      if (int_wr_en) begin
        wr_cnt     <= 1 + ({$random(seed)} % 4);
        int_wr_err <= int_addr[9];
        for (int b = 0; b < STRB_W; b++) begin
          if (int_wr_strb[b] && !int_addr[9]) begin
            mem[int_addr[9:2]][8*b +: 8] <= int_wr_data[8*b +: 8];
          end
        end
      end
      if (int_rd_en) begin
        rd_cnt      <= 1 + ({$random(seed)} % 4);
        int_rd_err  <= int_addr[9];
        int_rd_data <= mem[int_addr[9:2]];
      end
    end
  end

endmodule

//--- verification/tb_axi4l_bridge.sv
/* AXI4-Lite bridge testbench */
`timescale 1ns/1ps

module tb_axi4l_bridge
  import axi4l_bridge_pkg::*;
();

  // Writes, reads, error pair, same-cycle pair, stall mix
  localparam int N_TXN    = 12 + 12 + 2 + 2 + 24;
  localparam int WDOG_CYC = N_TXN * 200;

  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } wr_item_t;

  typedef struct packed {
    resp_e resp;
    data_t data;
  } rd_item_t;

  logic  aclk;
  logic  aresetn;
  addr_t s_axi_awaddr;
  logic  s_axi_awvalid;
  logic  s_axi_awready;
  data_t s_axi_wdata;
  strb_t s_axi_wstrb;
  logic  s_axi_wvalid;
  logic  s_axi_wready;
  resp_e s_axi_bresp;
  logic  s_axi_bvalid;
  logic  s_axi_bready;
  addr_t s_axi_araddr;
  logic  s_axi_arvalid;
  logic  s_axi_arready;
  data_t s_axi_rdata;
  resp_e s_axi_rresp;
  logic  s_axi_rvalid;
  logic  s_axi_rready;
  addr_t int_addr;
  data_t int_wr_data;
  strb_t int_wr_strb;
  logic  int_wr_en;
  logic  int_rd_en;
  logic  int_wr_ack;
  logic  int_wr_err;
  logic  int_rd_ack;
  logic  int_rd_err;
  data_t int_rd_data;

  // Reference model and scoreboard state
  data_t    ref_mem [256];
  wr_item_t wr_q [$];
  resp_e    b_q [$];
  addr_t    ar_q [$];
  rd_item_t r_q [$];
  wr_item_t wr_exp;
  rd_item_t rd_exp;
  integer   seed;
  int       err_cnt;
  int       chk_cnt;
  int       cyc;
  int       wr_cyc;
  int       rd_cyc;
  int       wr_out;
  int       rd_out;
  int       wr_issued;
  int       rd_issued;
  int       b_seen;
  int       r_seen;
  logic     req_seen;
  logic     stall_on;

  axi4l_bridge_top u_axi4l_bridge_top (.*);
  tb_int_target    u_tb_int_target (.*);

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  function automatic data_t merge_word(data_t old, data_t wdata, strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Upper half of the address map answers with DECERR
  function automatic resp_e resp_for(addr_t addr);
    return addr[9] ? RESP_DECERR : RESP_OKAY;
  endfunction

  task automatic note_fail(string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // ------------------------------------------------------------
  // AXI master tasks, order 0 AW first, 1 W first, 2 together
  // ------------------------------------------------------------
  task automatic axi_write(addr_t addr, data_t data, strb_t strb, int order);
    wr_item_t item;
    logic     aw_left;
    logic     w_left;
    logic     aw_fire;
    logic     w_fire;
    item.addr = addr;
    item.data = data;
    item.strb = strb;
    wr_q.push_back(item);
    b_q.push_back(resp_for(addr));
    if (!addr[9]) begin
      ref_mem[addr[9:2]] = merge_word(ref_mem[addr[9:2]], data, strb);
    end
    aw_left = 1'b1;
    w_left  = 1'b1;
    @(negedge aclk);
    req_seen = 1'b1;
    if (order != 1) begin
      s_axi_awaddr  = addr;
      s_axi_awvalid = 1'b1;
    end
    if (order != 0) begin
      s_axi_wdata  = data;
      s_axi_wstrb  = strb;
      s_axi_wvalid = 1'b1;
    end
    while (aw_left || w_left) begin
      // Ready is registered, so it holds until the next edge
      aw_fire = s_axi_awvalid & s_axi_awready;
      w_fire  = s_axi_wvalid & s_axi_wready;
      @(negedge aclk);
      if (aw_fire) begin
        s_axi_awvalid = 1'b0;
        aw_left       = 1'b0;
      end
      if (w_fire) begin
        s_axi_wvalid = 1'b0;
        w_left       = 1'b0;
      end
      // Second channel follows once the first has gone
      if (!aw_left && w_left && !s_axi_wvalid) begin
        s_axi_wdata  = data;
        s_axi_wstrb  = strb;
        s_axi_wvalid = 1'b1;
      end
      if (!w_left && aw_left && !s_axi_awvalid) begin
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
      end
    end
  endtask

  task automatic axi_read(addr_t addr);
    rd_item_t item;
    logic     fire;
    item.resp = resp_for(addr);
    item.data = ref_mem[addr[9:2]];
    ar_q.push_back(addr);
    r_q.push_back(item);
    @(negedge aclk);
    req_seen      = 1'b1;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    fire          = 1'b0;
    while (!fire) begin
      fire = s_axi_arready;
      @(negedge aclk);
    end
    s_axi_arvalid = 1'b0;
  endtask

  task automatic wait_idle();
    while (wr_q.size() != 0 || b_q.size() != 0 || ar_q.size() != 0 || r_q.size() != 0) begin
      @(posedge aclk);
    end
    repeat (2) @(posedge aclk);
  endtask

  // B and R back-pressure, random only while stalls are enabled
  initial begin
    s_axi_bready = 1'b1;
    s_axi_rready = 1'b1;
    forever begin
      @(negedge aclk);
      s_axi_bready = stall_on ? ({$random(seed)} % 3 == 0) : 1'b1;
      s_axi_rready = stall_on ? ({$random(seed)} % 3 == 0) : 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Scoreboard, strobe payloads and responses in order
  // ------------------------------------------------------------
  always @(posedge aclk) begin
    if (aresetn) begin
      cyc++;
      if (int_wr_en) begin
        wr_cyc = cyc;
        wr_out++;
        wr_issued++;
        if (wr_q.size() == 0) begin
          note_fail("Write strobe issued with no AXI write pending");
        end else begin
          wr_exp = wr_q.pop_front();
          check_val("int_addr", 32'(int_addr), 32'(wr_exp.addr));
          check_val("int_wr_data", int_wr_data, wr_exp.data);
          check_val("int_wr_strb", 32'(int_wr_strb), 32'(wr_exp.strb));
        end
      end
      if (int_rd_en) begin
        rd_cyc = cyc;
        rd_out++;
        rd_issued++;
        if (ar_q.size() == 0) begin
          note_fail("Read strobe issued with no AXI read pending");
        end else begin
          check_val("int_addr", 32'(int_addr), 32'(ar_q.pop_front()));
        end
      end
      if (int_wr_ack) begin
        wr_out--;
      end
      if (int_rd_ack) begin
        rd_out--;
      end
      if (s_axi_bvalid && s_axi_bready) begin
        b_seen++;
        if (b_seen > wr_issued || b_q.size() == 0) begin
          note_fail("Write response without a matching internal write");
        end else begin
          check_val("s_axi_bresp", 32'(s_axi_bresp), 32'(b_q.pop_front()));
        end
      end
      if (s_axi_rvalid && s_axi_rready) begin
        r_seen++;
        if (r_seen > rd_issued || r_q.size() == 0) begin
          note_fail("Read response without a matching internal read");
        end else begin
          rd_exp = r_q.pop_front();
          check_val("s_axi_rresp", 32'(s_axi_rresp), 32'(rd_exp.resp));
          // Data only defined on an OKAY read
          if (rd_exp.resp == RESP_OKAY) begin
            check_val("s_axi_rdata", s_axi_rdata, rd_exp.data);
          end
        end
      end
    end
  end

  // Protocol checks
  a_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
    !req_seen |-> !s_axi_bvalid && !s_axi_rvalid && !int_wr_en && !int_rd_en)
    else note_fail("Response or strobe seen before any request");
  a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
    else note_fail("bvalid or bresp changed while the master stalled");
  a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_rvalid && !s_axi_rready |=>
      s_axi_rvalid && $stable(s_axi_rresp) && $stable(s_axi_rdata))
    else note_fail("rvalid or R payload changed while the master stalled");
  a_one_wr: assert property (@(posedge aclk) disable iff (!aresetn)
    int_wr_en |-> wr_out == 0)
    else note_fail("Second write strobe while a write was outstanding");
  a_one_rd: assert property (@(posedge aclk) disable iff (!aresetn)
    int_rd_en |-> rd_out == 0)
    else note_fail("Second read strobe while a read was outstanding");

  initial begin
    repeat (WDOG_CYC) @(posedge aclk);
    $display("Timeout after %0d cycles with transactions still open", WDOG_CYC);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    $display("** FAIL **");
    $finish;
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    seed          = 32'h71b3;
    aresetn       = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    err_cnt       = 0;
    chk_cnt       = 0;
    cyc           = 0;
    wr_cyc        = 0;
    rd_cyc        = 0;
    wr_out        = 0;
    rd_out        = 0;
    wr_issued     = 0;
    rd_issued     = 0;
    b_seen        = 0;
    r_seen        = 0;
    req_seen      = 1'b0;
    stall_on      = 1'b0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3};
    end
    repeat (8) @(negedge aclk);
    aresetn = 1'b1;
    // Readies up after the first edge out of reset
    @(posedge aclk);
    @(negedge aclk);
    check_val("s_axi_awready", 32'(s_axi_awready), 32'h1);
    check_val("s_axi_wready", 32'(s_axi_wready), 32'h1);
    check_val("s_axi_arready", 32'(s_axi_arready), 32'h1);
    repeat (3) @(negedge aclk);

    // All three AW/W orders, then random ones
    for (int i = 0; i < 12; i++) begin
      axi_write(addr_t'(i * 4), data_t'($random(seed)), strb_t'($random(seed)),
        (i < 3) ? i : int'({$random(seed)} % 3));
    end
    wait_idle();
    for (int i = 0; i < 12; i++) begin
      axi_read(addr_t'(i * 4));
    end
    wait_idle();

    // Error region
    axi_write(10'h208, 32'hdead_beef, 4'hf, 2);
    axi_read(10'h20c);
    wait_idle();

    // Same-cycle write and read, write wins
    fork
      axi_write(10'h040, 32'h1234_5678, 4'hf, 2);
      axi_read(10'h080);
    join
    wait_idle();
    assert (wr_cyc < rd_cyc) else note_fail("Read strobe issued before the write strobe");

    // Random back-pressure, reads from a region not rewritten here
    stall_on = 1'b1;
    fork
      for (int i = 0; i < 12; i++) begin
        axi_write(addr_t'((64 + i) * 4) | ((i % 4 == 3) ? 10'h200 : 10'h000),
          data_t'($random(seed)), strb_t'($random(seed)), int'({$random(seed)} % 3));
      end
      for (int j = 0; j < 12; j++) begin
        axi_read(addr_t'((j % 8) * 4) | ((j % 5 == 4) ? 10'h200 : 10'h000));
      end
    join
    wait_idle();
    stall_on = 1'b0;
    repeat (4) @(posedge aclk);

    if (b_seen != wr_issued || r_seen != rd_issued) begin
      note_fail("Response count does not match issued internal commands");
    end
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/axi4l_bridge_pkg.sv
design/wr_cmd_if.sv
design/txn_track_if.sv
design/axi_wr_capture.sv
design/axi_rd_capture.sv
design/int_bus_arbiter.sv
design/axi_resp_ctrl.sv
design/axi4l_bridge_top.sv
verification/tb_int_target.sv
verification/tb_axi4l_bridge.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_axi4l_bridge
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
